//--- Makefile
VERILATOR ?= verilator
TOP       := decodeStageTb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0
RUN_ARGS  := +verilator+error+limit+1000
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
src/isaPkg.sv
src/ctrlPkg.sv
src/controlUnit.sv
src/aluOpDecode.sv
src/regFile.sv
src/decodeStage.sv
testbench/decodeStage_properties.sv
testbench/decodeStageTb.sv

//--- src/aluOpDecode.sv
// ALU operation decoder
// picks the ALU code from the opcode, and from func for register ALU ops
`timescale 1ns/1ps

module aluOpDecode import isaPkg::*, ctrlPkg::*; (
   input  instrWord_t  instruction,
   output logic [3:0]  aluOp
);

   always_comb begin
      case (instruction.rFmt.opcode)
         opAddi: aluOp = AluAdd;
         opSubi: aluOp = AluSub;
         opXori: aluOp = AluXor;
         opAndni: aluOp = AluAndn;
         opRalu: begin
            case (instruction.rFmt.func)
               2'b00: aluOp = AluAdd;
               2'b01: aluOp = AluSub;
               2'b10: aluOp = AluXor;
               default: aluOp = AluAndn;
            endcase
         end
         // branches test rs against zero
         opBeqz, opBnez, opBltz, opBgez: aluOp = AluCmpZero;
         opSt, opLd, opStu: aluOp = AluAdd;   // address = base + offset
         opJ, opJal: aluOp = AluPassB;        // imm11 through to the adder
         opLbi, opSlbi: aluOp = AluPassB;
         default: aluOp = AluAdd;             // HALT, NOP and undefined
      endcase
   end

endmodule

//--- src/controlUnit.sv
// instruction control unit
// turns the opcode into control strobes, operand selects and an error flag
`timescale 1ns/1ps

module controlUnit import isaPkg::*, ctrlPkg::*; (
   input  instrWord_t instruction,
   output rawCtrl_t   rawCtrl,
   output logic       err
);

   always_comb begin
      // defaults give NOP behaviour
      rawCtrl = '0;
      rawCtrl.base.wbSel = wbAlu;
      rawCtrl.base.branchCond = brNone;
      rawCtrl.bSrc = bZero;
      rawCtrl.destSel = destRs;
      err = 1'b0;

      case (instruction.rFmt.opcode)
         opHalt: rawCtrl.base.halt = 1'b1;
         opNop: ; // nothing to do
         opJ: begin
            rawCtrl.base.jump = 1'b1;
            rawCtrl.base.immPcRel = 1'b1;
            rawCtrl.bSrc = bImm11;
         end
         opJal: begin
            rawCtrl.base.jump = 1'b1;
            rawCtrl.base.jumpLink = 1'b1;
            rawCtrl.base.immPcRel = 1'b1;
            rawCtrl.base.regWrite = 1'b1;
            rawCtrl.base.wbSel = wbRetPc; // return address into r7
            rawCtrl.destSel = destR7;
            rawCtrl.bSrc = bImm11;
         end
         opAddi, opSubi, opXori, opAndni: begin
            rawCtrl.base.regWrite = 1'b1;
            rawCtrl.bSrc = bImm5;
            rawCtrl.destSel = destRt;
            // SUBI computes imm - rs
            rawCtrl.base.invA = (instruction.rFmt.opcode == opSubi);
            rawCtrl.base.carryIn = (instruction.rFmt.opcode == opSubi);
            rawCtrl.base.invB = (instruction.rFmt.opcode == opAndni);
            rawCtrl.zeroExt = (instruction.rFmt.opcode == opXori) ||
                              (instruction.rFmt.opcode == opAndni);
         end
         opBeqz: begin
            rawCtrl.base.branchCond = brEqz;
            rawCtrl.bSrc = bReg;
         end
         opBnez: begin
            rawCtrl.base.branchCond = brNez;
            rawCtrl.bSrc = bReg;
         end
         opBltz: begin
            rawCtrl.base.branchCond = brLtz;
            rawCtrl.bSrc = bReg;
         end
         opBgez: begin
            rawCtrl.base.branchCond = brGez;
            rawCtrl.bSrc = bReg;
         end
         opSt: begin
            rawCtrl.base.memWrite = 1'b1;
            rawCtrl.bSrc = bImm5; // address offset
         end
         opLd: begin
            rawCtrl.base.regWrite = 1'b1;
            rawCtrl.base.wbSel = wbMem;
            rawCtrl.bSrc = bImm5;
            rawCtrl.destSel = destRt;
         end
         opStu: begin
            rawCtrl.base.memWrite = 1'b1;
            rawCtrl.base.regWrite = 1'b1; // updated base back into rs
            rawCtrl.base.storeUpper = 1'b1;
            rawCtrl.bSrc = bReg;
            rawCtrl.destSel = destRs;
         end
         opSlbi: begin
            rawCtrl.base.regWrite = 1'b1;
            rawCtrl.base.shiftLoad = 1'b1;
            rawCtrl.zeroExt = 1'b1;   // imm8 is unsigned here
            rawCtrl.destSel = destRs;
         end
         opLbi: begin
            rawCtrl.base.regWrite = 1'b1;
            rawCtrl.base.wbSel = wbImm;
            rawCtrl.destSel = destRs;
         end
         opRalu: begin
            rawCtrl.base.regWrite = 1'b1;
            rawCtrl.bSrc = bReg;
            rawCtrl.destSel = destRd;
            rawCtrl.base.invA = (instruction.rFmt.func == 2'b01);    // SUB
            rawCtrl.base.carryIn = (instruction.rFmt.func == 2'b01);
            rawCtrl.base.invB = (instruction.rFmt.func == 2'b11);    // ANDN
         end
         default: err = 1'b1; // undefined opcode, NOP settings stay
      endcase

      rawCtrl.base.memRead = (rawCtrl.base.wbSel == wbMem);
   end

endmodule

//--- src/ctrlPkg.sv
// decoded control fields for the decode stage
// select encodings, ALU operation codes and the control bundles

package ctrlPkg;

   typedef enum logic [1:0] {
      wbAlu   = 2'b00,
      wbMem   = 2'b01,
      wbRetPc = 2'b10,  // PC+2 for JAL
      wbImm   = 2'b11   // LBI result
   } wbSel_t;

   typedef enum logic [1:0] {
      bReg   = 2'b00,
      bImm5  = 2'b01,
      bImm11 = 2'b10,
      bZero  = 2'b11
   } bSrc_t;

   typedef enum logic [1:0] {
      destRs = 2'b00, // instruction[10:8]
      destRt = 2'b01, // instruction[7:5]
      destRd = 2'b10, // instruction[4:2]
      destR7 = 2'b11  // link register
   } destSel_t;

   typedef enum logic [2:0] {
      brNone = 3'b000,
      brEqz  = 3'b100,
      brNez  = 3'b101,
      brLtz  = 3'b110,
      brGez  = 3'b111
   } branchCond_t;

   // ALU operation codes
   localparam logic [3:0] AluAdd     = 4'h0;
   localparam logic [3:0] AluSub     = 4'h1;
   localparam logic [3:0] AluXor     = 4'h2;
   localparam logic [3:0] AluAndn    = 4'h3;
   localparam logic [3:0] AluPassB   = 4'h4;
   localparam logic [3:0] AluCmpZero = 4'h5; // branch test on rs

   typedef struct packed {
      logic [3:0] aluOp;
      logic regWrite;
      logic memWrite;
      logic memRead;
      wbSel_t wbSel;
      branchCond_t branchCond;
      logic jump;
      logic jumpLink;
      logic immPcRel;    // 1: imm11 added to PC, 0: imm8
      logic invA;
      logic invB;
      logic carryIn;
      logic storeUpper;  // STU
      logic shiftLoad;   // SLBI
      logic halt;
   } decodeCtrl_t;

   // control unit output, selects are used only inside decode
   typedef struct packed {
      decodeCtrl_t base;
      bSrc_t bSrc;
      destSel_t destSel;
      logic zeroExt;     // zero-extend imm5 and imm8
   } rawCtrl_t;

endpackage

//--- src/decodeStage.sv
// decode stage top level
// NOP substitution, immediate generation, operand and destination muxing,
// control unit, ALU op decoder and register file
`timescale 1ns/1ps

module decodeStage import isaPkg::*, ctrlPkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  instrWord_t           instruction,
   input  logic                 instrValid,
   input  logic [DataWidth-1:0] wbData,
   input  logic                 wbWrite,
   input  regIdx_t              wbReg,
   output decodeCtrl_t          ctrl,
   output regIdx_t              destReg,
   output logic [DataWidth-1:0] imm8,
   output logic [DataWidth-1:0] imm11,
   output logic [DataWidth-1:0] inA,
   output logic [DataWidth-1:0] inB,
   output logic [DataWidth-1:0] storeData,
   output logic                 branchInst,
   output logic                 err
);

   instrWord_t decInstr;            // word seen by the decoders
   rawCtrl_t rawCtrl;
   logic [3:0] aluOp;
   logic [DataWidth-1:0] imm5;
   logic [DataWidth-1:0] regB;      // rt read port

   assign decInstr = instrValid ? instruction : NopWord;

   controlUnit i_controlUnit (
      .instruction(decInstr),
      .rawCtrl(rawCtrl),
      .err(err)
   );

   aluOpDecode i_aluOpDecode (
      .instruction(decInstr),
      .aluOp(aluOp)
   );

   regFile i_regFile (
      .clk(clk),
      .rst(rst),
      .readSel1(instruction.rFmt.rs),
      .readSel2(instruction.rFmt.rt),
      .writeSel(wbReg),
      .writeData(wbData),
      .writeEn(wbWrite),
      .readData1(inA),
      .readData2(regB)
   );

   // immediates, imm11 always signed
   assign imm5 = rawCtrl.zeroExt ? {11'b0, instruction.i1Fmt.imm5}
                                 : {{11{instruction.i1Fmt.imm5[4]}}, instruction.i1Fmt.imm5};
   assign imm8 = rawCtrl.zeroExt ? {8'b0, instruction.i2Fmt.imm8}
                                 : {{8{instruction.i2Fmt.imm8[7]}}, instruction.i2Fmt.imm8};
   assign imm11 = {{5{instruction.jFmt.disp11[10]}}, instruction.jFmt.disp11};

   always_comb begin
      case (rawCtrl.bSrc)
         bReg: inB = regB;
         bImm5: inB = imm5;
         bImm11: inB = imm11;
         default: inB = '0;
      endcase
   end

   assign storeData = rawCtrl.base.storeUpper ? regB : inB; // STU stores rt

   always_comb begin
      case (rawCtrl.destSel)
         destRs: destReg = instruction.rFmt.rs;
         destRt: destReg = instruction.rFmt.rt;
         destRd: destReg = instruction.rFmt.rd;
         default: destReg = 3'd7;   // JAL link
      endcase
   end

   always_comb begin
      ctrl = rawCtrl.base;
      ctrl.aluOp = aluOp;            // fill in from the op decoder
   end

   // opcodes 011xx and 001xx redirect the PC
   assign branchInst = (decInstr.rFmt.opcode[4:2] == 3'b011) ||
                       (decInstr.rFmt.opcode[4:2] == 3'b001);

endmodule

//--- src/isaPkg.sv
// ISA definitions for the 16-bit eight-register teaching processor
// word width, register count, opcode encodings and instruction formats

package isaPkg;

   localparam int DataWidth = 16; // data and instruction word width
   localparam int NumRegs = 8;

   typedef logic [2:0] regIdx_t; // register index

   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJal   = 5'b00110,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opStu   = 5'b10011,
      opLbi   = 5'b11000,
      opRalu  = 5'b11011   // register ALU group, func picks the op
   } opcode_t;

   // one instruction word, seen through each encoding format
   typedef union packed {
      struct packed {
         opcode_t opcode;
         regIdx_t rs;       // [10:8]
         regIdx_t rt;       // [7:5]
         regIdx_t rd;       // [4:2]
         logic [1:0] func;  // add, sub, xor, andn
      } rFmt;
      struct packed {
         opcode_t opcode;
         regIdx_t rs;
         regIdx_t rd;       // [7:5]
         logic [4:0] imm5;
      } i1Fmt;
      struct packed {
         opcode_t opcode;
         regIdx_t rs;
         logic [7:0] imm8;
      } i2Fmt;
      struct packed {
         opcode_t opcode;
         logic [10:0] disp11; // jump displacement
      } jFmt;
   } instrWord_t;

   localparam instrWord_t NopWord = {opNop, 11'b0}; // fed to decode when slot is empty

endpackage

//--- src/regFile.sv
// register file, eight 16-bit registers
// two combinational read ports, one write port at the clock edge
`timescale 1ns/1ps

module regFile import isaPkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  regIdx_t              readSel1,
   input  regIdx_t              readSel2,
   input  regIdx_t              writeSel,
   input  logic [DataWidth-1:0] writeData,
   input  logic                 writeEn,
   output logic [DataWidth-1:0] readData1,
   output logic [DataWidth-1:0] readData2
);

   logic [DataWidth-1:0] regs [NumRegs];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0; // all registers read zero after reset
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

   // reads see the old value during a write cycle
   assign readData1 = regs[readSel1];
   assign readData2 = regs[readSel2];

endmodule

//--- testbench/decodeStageTb.sv
// testbench for the decode stage
// random words from an LFSR, a reference model of the decode rules,
// immediate assertions against the model and a cycle limit
`timescale 1ns/1ps

module decodeStageTb import isaPkg::*, ctrlPkg::*; ();

   localparam int ResetCycles = 2;
   localparam int QuietVectors = 16;   // no writes yet, reset values on the ports
   localparam int NumVectors = 400;
   localparam int CycleLimit = ResetCycles + NumVectors + 50;

   logic clk;
   logic rst;
   instrWord_t instruction;
   logic instrValid;
   logic [DataWidth-1:0] wbData;
   logic wbWrite;
   regIdx_t wbReg;
   decodeCtrl_t ctrl;
   regIdx_t destReg;
   logic [DataWidth-1:0] imm8;
   logic [DataWidth-1:0] imm11;
   logic [DataWidth-1:0] inA;
   logic [DataWidth-1:0] inB;
   logic [DataWidth-1:0] storeData;
   logic branchInst;
   logic err;

   logic [15:0] lfsr = 16'd94;
   logic [DataWidth-1:0] shadowRegs [NumRegs];   // model copy of the register file
   int errorCount = 0;
   int cycleCount = 0;

   decodeStage i_decodeStage (
      .clk(clk),
      .rst(rst),
      .instruction(instruction),
      .instrValid(instrValid),
      .wbData(wbData),
      .wbWrite(wbWrite),
      .wbReg(wbReg),
      .ctrl(ctrl),
      .destReg(destReg),
      .imm8(imm8),
      .imm11(imm11),
      .inA(inA),
      .inB(inB),
      .storeData(storeData),
      .branchInst(branchInst),
      .err(err)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CycleLimit) begin
         $display("timeout: run still going after %0d cycles", cycleCount);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // galois LFSR, taps 16,14,13,11
   function automatic logic [15:0] lfsrStep(input logic [15:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 16'hB400;
      end
      return state >> 1;
   endfunction

   function automatic logic [15:0] takeBits(input int n);
      logic [15:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         value = {value[14:0], lfsr[0]};   // one step per bit
         lfsr = lfsrStep(lfsr);
      end
      return value;
   endfunction

   // add, sub, xor, andn in function-bit order
   function automatic logic [3:0] aluForSel(input logic [1:0] sel);
      case (sel)
         2'b00: return AluAdd;
         2'b01: return AluSub;
         2'b10: return AluXor;
         default: return AluAndn;
      endcase
   endfunction

   task automatic checkValue(input string name, input logic [15:0] expVal,
                             input logic [15:0] actVal);
      assert (actVal === expVal) else begin
         errorCount++;
         $display("[ERROR] %s expected %h got %h at %0t", name, expVal, actVal, $time);
      end
   endtask

   task automatic compareWithModel();
      logic [15:0] word;
      logic [4:0] op;
      logic zext;
      logic known;
      logic expRegWrite;
      logic expMemWrite;
      logic expJump;
      logic expLink;
      logic expPcRel;
      logic expUpper;
      logic expShift;
      logic expHalt;
      logic expInvA;
      logic expInvB;
      logic [1:0] expWbSel;
      logic [1:0] expBSrc;
      logic [2:0] expCond;
      logic [2:0] expDest;
      logic [3:0] expAluOp;
      logic [15:0] expImm5;
      logic [15:0] expImm8;
      logic [15:0] expImm11;
      logic [15:0] regB;
      logic [15:0] expInB;
      logic [15:0] expStore;
      logic expBranch;

      word = instruction;
      op = instrValid ? word[15:11] : opNop;   // empty slot decodes as NOP
      known = 1'b1;
      zext = 1'b0;
      expRegWrite = 1'b0;
      expMemWrite = 1'b0;
      expJump = 1'b0;
      expLink = 1'b0;
      expPcRel = 1'b0;
      expUpper = 1'b0;
      expShift = 1'b0;
      expHalt = 1'b0;
      expInvA = 1'b0;
      expInvB = 1'b0;
      expWbSel = wbAlu;
      expBSrc = bZero;
      expCond = brNone;
      expDest = word[10:8];
      expAluOp = AluAdd;   // also memory address add

      case (op)
         opHalt: expHalt = 1'b1;
         opNop: ;
         opJ, opJal: begin
            expJump = 1'b1;
            expPcRel = 1'b1;   // jumps add imm11 to the PC
            expBSrc = bImm11;
            expAluOp = AluPassB;
            if (op == opJal) begin
               expRegWrite = 1'b1;
               expLink = 1'b1;
               expWbSel = wbRetPc;
               expDest = 3'd7;   // link register
            end
         end
         opAddi, opSubi, opXori, opAndni: begin
            expRegWrite = 1'b1;
            expBSrc = bImm5;
            expDest = word[7:5];
            expAluOp = aluForSel(op[1:0]);
            expInvA = (op == opSubi);
            expInvB = (op == opAndni);
            zext = (op == opXori) || (op == opAndni);
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            expBSrc = bReg;
            expAluOp = AluCmpZero;
            case (op)
               opBeqz: expCond = brEqz;
               opBnez: expCond = brNez;
               opBltz: expCond = brLtz;
               default: expCond = brGez;
            endcase
         end
         opSt: begin
            expMemWrite = 1'b1;
            expBSrc = bImm5;
         end
         opLd: begin
            expRegWrite = 1'b1;
            expWbSel = wbMem;
            expBSrc = bImm5;
            expDest = word[7:5];
         end
         opStu: begin
            expMemWrite = 1'b1;
            expRegWrite = 1'b1;
            expUpper = 1'b1;
            expBSrc = bReg;
         end
         opSlbi: begin
            expRegWrite = 1'b1;
            expShift = 1'b1;
            expAluOp = AluPassB;
            zext = 1'b1;
         end
         opLbi: begin
            expRegWrite = 1'b1;
            expWbSel = wbImm;
            expAluOp = AluPassB;
         end
         opRalu: begin
            expRegWrite = 1'b1;
            expBSrc = bReg;
            expDest = word[4:2];
            expAluOp = aluForSel(word[1:0]);
            expInvA = (word[1:0] == 2'b01);
            expInvB = (word[1:0] == 2'b11);
         end
         default: known = 1'b0;
      endcase

      expImm5 = zext ? {11'b0, word[4:0]} : {{11{word[4]}}, word[4:0]};
      expImm8 = zext ? {8'b0, word[7:0]} : {{8{word[7]}}, word[7:0]};
      expImm11 = {{5{word[10]}}, word[10:0]};
      regB = shadowRegs[word[7:5]];
      case (expBSrc)
         bReg: expInB = regB;
         bImm5: expInB = expImm5;
         bImm11: expInB = expImm11;
         default: expInB = '0;
      endcase
      expStore = (op == opStu) ? regB : expInB;   // STU stores rt
      expBranch = (op[4:2] == 3'b011) || (op[4:2] == 3'b001);

      checkValue("imm8", expImm8, imm8);
      checkValue("imm11", expImm11, imm11);
      checkValue("inA", shadowRegs[word[10:8]], inA);
      checkValue("inB", expInB, inB);
      checkValue("storeData", expStore, storeData);
      checkValue("ctrl.aluOp", 16'(expAluOp), 16'(ctrl.aluOp));
      checkValue("ctrl.regWrite", 16'(expRegWrite), 16'(ctrl.regWrite));
      checkValue("ctrl.memWrite", 16'(expMemWrite), 16'(ctrl.memWrite));
      checkValue("ctrl.memRead", 16'(expWbSel == wbMem), 16'(ctrl.memRead));
      checkValue("ctrl.wbSel", 16'(expWbSel), 16'(ctrl.wbSel));
      checkValue("ctrl.branchCond", 16'(expCond), 16'(ctrl.branchCond));
      checkValue("ctrl.jump", 16'(expJump), 16'(ctrl.jump));
      checkValue("ctrl.jumpLink", 16'(expLink), 16'(ctrl.jumpLink));
      checkValue("ctrl.immPcRel", 16'(expPcRel), 16'(ctrl.immPcRel));
      checkValue("ctrl.storeUpper", 16'(expUpper), 16'(ctrl.storeUpper));
      checkValue("ctrl.shiftLoad", 16'(expShift), 16'(ctrl.shiftLoad));
      checkValue("ctrl.halt", 16'(expHalt), 16'(ctrl.halt));
      checkValue("ctrl.invA", 16'(expInvA), 16'(ctrl.invA));
      checkValue("ctrl.carryIn", 16'(expInvA), 16'(ctrl.carryIn));   // follows invA
      checkValue("ctrl.invB", 16'(expInvB), 16'(ctrl.invB));
      checkValue("branchInst", 16'(expBranch), 16'(branchInst));
      checkValue("err", 16'(!known), 16'(err));
      if (expRegWrite) begin
         checkValue("destReg", 16'(expDest), 16'(destReg));   // only meaningful on writes
      end
   endtask

   initial begin
      logic [15:0] r;
      instrWord_t holdWord;
      int propFails;

      clk = 1'b0;
      rst = 1'b1;
      instruction = NopWord;
      instrValid = 1'b0;
      wbData = '0;
      wbWrite = 1'b0;
      wbReg = '0;
      holdWord = NopWord;
      for (int i = 0; i < NumRegs; i++) begin
         shadowRegs[i] = '0;
      end

      repeat (ResetCycles) @(posedge clk);
      rst <= 1'b0;

      for (int v = 0; v < NumVectors; v++) begin
         @(posedge clk);
         if (wbWrite) begin
            shadowRegs[wbReg] = wbData;   // DUT took this write at the edge
         end
         r = takeBits(1);
         if (r[0] == 1'b0 || v == 0) begin
            r = takeBits(16);
            holdWord = r;   // otherwise hold the word to exercise the no-bypass case
         end
         instruction <= holdWord;
         r = takeBits(2);
         instrValid <= (r[1:0] != 2'b00);   // valid three times in four
         r = takeBits(16);
         wbData <= r;
         r = takeBits(1);
         wbWrite <= (v >= QuietVectors) && r[0];
         r = takeBits(1);
         if (r[0]) begin
            wbReg <= holdWord.rFmt.rs;   // aim at the register being read
         end else begin
            r = takeBits(3);
            wbReg <= r[2:0];
         end
         @(negedge clk);
         compareWithModel();
      end

      // last write lands, then its bound checks run at the following edge
      repeat (2) @(posedge clk);
      @(negedge clk);
      propFails = i_decodeStage.i_decodeStageProperties.failCount;
      $display("errors: %0d from checks, %0d from bound properties", errorCount, propFails);
      if (errorCount == 0 && propFails == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- testbench/decodeStage_properties.sv
// decode stage properties, bound into the top level
// register reset state, write timing and empty-slot strobes
`timescale 1ns/1ps

module decodeStageProperties import isaPkg::*, ctrlPkg::*; (
   input logic                 clk,
   input logic                 rst,
   input instrWord_t           instruction,
   input logic                 instrValid,
   input logic                 wbWrite,
   input regIdx_t              wbReg,
   input logic [DataWidth-1:0] wbData,
   input decodeCtrl_t          ctrl,
   input logic                 err,
   input logic [DataWidth-1:0] inA,
   input logic [DataWidth-1:0] regB
);

   int failCount = 0;   // tally for the closing line
   logic written;       // a write has landed since reset

   always_ff @(posedge clk) begin
      if (rst) begin
         written <= 1'b0;
      end else if (wbWrite) begin
         written <= 1'b1;
      end
   end

   // nothing written yet, both read ports see zero
   resetZero: assert property (@(posedge clk) disable iff (rst)
      !written |-> (inA == '0 && regB == '0))
   else begin
      failCount++;
      $error("register read nonzero before any write");
   end

   // one cycle after a write, an rs matching the target shows the new data
   writeVisible: assert property (@(posedge clk) disable iff (rst)
      wbWrite |=> (instruction.rFmt.rs != $past(wbReg) || inA == $past(wbData)))
   else begin
      failCount++;
      $error("written data not visible on inA in the next cycle");
   end

   // held rs keeps its old value during the write cycle
   noBypass: assert property (@(posedge clk) disable iff (rst)
      (wbWrite && wbReg == instruction.rFmt.rs && $stable(instruction.rFmt.rs)
       && !$past(wbWrite)) |-> $stable(inA))
   else begin
      failCount++;
      $error("write data bypassed to inA in the same cycle");
   end

   invalidQuiet: assert property (@(posedge clk) disable iff (rst)
      !instrValid |-> !(ctrl.regWrite || ctrl.memWrite || ctrl.memRead ||
                        ctrl.jump || ctrl.halt || err))
   else begin
      failCount++;
      $error("strobe or err active with instrValid low");
   end

endmodule

bind decodeStage decodeStageProperties i_decodeStageProperties (
   .clk(clk),
   .rst(rst),
   .instruction(instruction),
   .instrValid(instrValid),
   .wbWrite(wbWrite),
   .wbReg(wbReg),
   .wbData(wbData),
   .ctrl(ctrl),
   .err(err),
   .inA(inA),
   .regB(regB)
);
